/* hdl/pat_config.svh */
`ifndef PAT_CONFIG_SVH
`define PAT_CONFIG_SVH

// ==================================================
// datapath widths
// ==================================================
`define PAT_I_WIDTH         20 // one instruction word
`define PAT_D_WIDTH         8  // acc, field and memory words
`define PAT_FIELDP_WIDTH    5  // field pointer
`define PAT_BUFP_WIDTH      3  // buffer pointer

// ==================================================
// data memory and field timing
// ==================================================
`define PAT_DMEM_ADR_WIDTH  4
`define PAT_DMEM_DEPTH      16
`define PAT_FIELD_LATENCY   4  // cycles from field read to field write

// ==================================================
// encodings
// ==================================================
`define PAT_INSTR_NOP       20'h06ff5 // i0 nop, cond always, fieldp 0
`define PAT_PREFIX          4'b1111   // escape into the next class down

// condition codes, code 3 behaves as always
`define PAT_COND_AL         2'd0
`define PAT_COND_Z          2'd1
`define PAT_COND_N          2'd2

`endif

/* hdl/pat_pkg.sv */
`include "pat_config.svh"

package pat_pkg;

	// ==================================================
	// vector types
	// ==================================================

	// fieldp | cond | field_op | i8 opcode | imm8
	typedef logic [`PAT_I_WIDTH-1:0] instr_t;

	typedef logic [`PAT_D_WIDTH-1:0] data_t; // acc / field / dmem word

	typedef logic [`PAT_FIELDP_WIDTH-1:0] fieldp_t;

	typedef logic [`PAT_BUFP_WIDTH-1:0] bufp_t;

	typedef logic [`PAT_DMEM_ADR_WIDTH-1:0] dmem_adr_t;

	typedef logic [1:0] cond_t; // al / z / n

	// ==================================================
	// alu operation
	// ==================================================
	typedef enum logic [3:0]
	{
		alu_or,
		alu_and,
		alu_not,    // ignores b
		alu_add,
		alu_sub,    // a - b
		alu_shl,    // shifts take b[2:0]
		alu_shlo,   // shift left, ones in from the bottom
		alu_shr,
		alu_asr,
		alu_pass_b  // loads and the idle case
	} alu_op_e;

	// ==================================================
	// decoded control of one instruction
	// ==================================================
	typedef struct packed
	{
		alu_op_e alu_op;
		cond_t   cond;
		logic    field_op;   // op works on the field, not acc
		logic    dest_acc;
		logic    dest_field;
		logic    dest_dmem;  // stm
		logic    src_imm;    // ldi, result is alu_b
		logic    src_in;     // in, result is i_inputs
		logic    op_mov;     // ldba or ldab, by field_op
		logic    op_test;
		logic    op_out;
		logic    op_setb;
	} ctrl_t;

endpackage

/* hdl/pat_alu.sv */
`timescale 1ns/1ps

module pat_alu
(
	input  pat_pkg::data_t  i_a,
	input  pat_pkg::data_t  i_b,
	input  pat_pkg::alu_op_e i_op,
	output pat_pkg::data_t  o_y
);

	logic [2:0]     shamt;     // shift distance
	pat_pkg::data_t ones_mask; // low shamt bits set, for shlo

	assign shamt = i_b[2:0];
	assign ones_mask = ~({$bits(pat_pkg::data_t){1'b1}} << shamt);

	// ==================================================
	// operation select
	// ==================================================
	always_comb
	begin
		case (i_op)
			pat_pkg::alu_or:
				o_y = i_a | i_b;
			pat_pkg::alu_and:
				o_y = i_a & i_b;
			pat_pkg::alu_not:
				o_y = ~i_a;
			pat_pkg::alu_add:
				o_y = i_a + i_b;      // carry out dropped
			pat_pkg::alu_sub:
				o_y = i_a - i_b;
			pat_pkg::alu_shl:
				o_y = i_a << shamt;
			pat_pkg::alu_shlo:
				o_y = (i_a << shamt) | ones_mask;
			pat_pkg::alu_shr:
				o_y = i_a >> shamt;   // logical
			pat_pkg::alu_asr:
				o_y = pat_pkg::data_t'($signed(i_a) >>> shamt); // sign fill
			default:
				o_y = i_b;            // pass b, ldm
		endcase
	end

endmodule

/* hdl/pat_data_mem.sv */
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_data_mem
(
	input  logic               clk,
	input  pat_pkg::dmem_adr_t i_radr,
	input  pat_pkg::dmem_adr_t i_wadr,
	input  logic               i_we,
	input  pat_pkg::data_t     i_wdata,
	output pat_pkg::data_t     o_rdata
);

	pat_pkg::data_t mem [`PAT_DMEM_DEPTH]; // unknown until first stm

	// read is combinational, decode registers it
	assign o_rdata = mem[i_radr];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_wadr] <= i_wdata;
	end

endmodule

/* hdl/pat_decode.sv */
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_decode
(
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::instr_t    i_instruction,
	input  logic               i_field_sel,     // 1 = high half
	input  pat_pkg::data_t     i_field_in_low,
	input  pat_pkg::data_t     i_field_in_high,
	input  pat_pkg::data_t     i_dmem_rdata,
	output pat_pkg::dmem_adr_t o_dmem_radr,
	output pat_pkg::ctrl_t     o_ctrl,
	output pat_pkg::data_t     o_alu_b,
	output pat_pkg::data_t     o_field_value,
	output pat_pkg::data_t     o_imm,
	output pat_pkg::fieldp_t   o_fieldp,
	output pat_pkg::fieldp_t   o_fieldwp
);

	pat_pkg::instr_t  instr_q;    // stage 1 instruction register
	pat_pkg::fieldp_t fieldp_next;
	pat_pkg::cond_t   cond;
	logic             field_op;
	logic [3:0]       op8;
	logic [7:0]       imm8;
	logic             is_i8, is_i3;
	logic             dest_reg;   // result goes to acc or field
	logic             src_dmem;   // b operand comes from memory
	pat_pkg::data_t   imm_next;
	pat_pkg::ctrl_t   ctrl_next;
	pat_pkg::fieldp_t fieldp_hist [`PAT_FIELD_LATENCY];

	assign {fieldp_next, cond, field_op, op8, imm8} = instr_q;

	// class decode, i3 and i0 both escape through the prefix
	assign is_i8 = (op8 != `PAT_PREFIX);
	assign is_i3 = !is_i8 && (imm8[7:4] != `PAT_PREFIX);

	// i3 keeps bit 3 too, setb uses it as the half select
	assign imm_next = is_i8 ? imm8 : {4'b0000, imm8[3:0]};

	assign o_dmem_radr = imm8[`PAT_DMEM_ADR_WIDTH-1:0]; // async read, sampled below

	// ==================================================
	// opcode decode
	// ==================================================
	always_comb
	begin
		ctrl_next = '0;
		ctrl_next.alu_op = pat_pkg::alu_pass_b;
		ctrl_next.cond = cond;
		ctrl_next.field_op = field_op;
		dest_reg = 1'b0;
		src_dmem = 1'b0;
		if (is_i8)
		begin
			case (op8)
				4'h0: begin ctrl_next.alu_op = pat_pkg::alu_or;  dest_reg = 1'b1; end
				4'h1: begin ctrl_next.alu_op = pat_pkg::alu_and; dest_reg = 1'b1; end
				4'h2: begin ctrl_next.alu_op = pat_pkg::alu_add; dest_reg = 1'b1; src_dmem = 1'b1; end
				4'h3: begin ctrl_next.alu_op = pat_pkg::alu_sub; dest_reg = 1'b1; src_dmem = 1'b1; end
				4'h4: begin ctrl_next.alu_op = pat_pkg::alu_add; dest_reg = 1'b1; end
				4'h5: begin ctrl_next.alu_op = pat_pkg::alu_sub; dest_reg = 1'b1; end
				4'h6: begin ctrl_next.src_imm = 1'b1; dest_reg = 1'b1; end // ldi
				4'h7: begin dest_reg = 1'b1; src_dmem = 1'b1; end          // ldm, pass b
				4'hB: ctrl_next.dest_dmem = 1'b1;                          // stm
				4'hD: begin ctrl_next.alu_op = pat_pkg::alu_or;  dest_reg = 1'b1; src_dmem = 1'b1; end
				4'hE: begin ctrl_next.alu_op = pat_pkg::alu_and; dest_reg = 1'b1; src_dmem = 1'b1; end
				default: ; // branch / call / setsp codes do nothing
			endcase
		end
		else if (is_i3)
		begin
			case (imm8[7:4])
				4'h0: begin ctrl_next.alu_op = pat_pkg::alu_shl;  dest_reg = 1'b1; end
				4'h1: begin ctrl_next.alu_op = pat_pkg::alu_shlo; dest_reg = 1'b1; end
				4'h2: begin ctrl_next.alu_op = pat_pkg::alu_shr;  dest_reg = 1'b1; end
				4'h3: begin ctrl_next.alu_op = pat_pkg::alu_asr;  dest_reg = 1'b1; end
				4'h5: begin ctrl_next.src_in = 1'b1; dest_reg = 1'b1; end // in
				4'h8: ctrl_next.op_out = 1'b1;
				4'h9: ctrl_next.op_setb = 1'b1;
				default: ;
			endcase
		end
		else
		begin
			case (imm8[3:0])
				4'h0: begin ctrl_next.alu_op = pat_pkg::alu_not; dest_reg = 1'b1; end
				4'h1: begin ctrl_next.op_mov = 1'b1; dest_reg = 1'b1; end
				4'h2: ctrl_next.op_test = 1'b1;
				default: ; // nop and return / sp codes
			endcase
		end
		ctrl_next.dest_acc = dest_reg && !field_op;
		ctrl_next.dest_field = dest_reg && field_op;
	end

	// ==================================================
	// pipeline registers
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q <= `PAT_INSTR_NOP;
			o_ctrl <= '0; // all dests clear, nothing commits
			o_fieldp <= '0;
			o_fieldwp <= '0;
			for (int i = 0; i < `PAT_FIELD_LATENCY; i++)
				fieldp_hist[i] <= '0;
		end
		else
		begin
			instr_q <= i_instruction;
			o_ctrl <= ctrl_next;
			o_fieldp <= fieldp_next;
			fieldp_hist[0] <= o_fieldp;
			for (int i = 1; i < `PAT_FIELD_LATENCY; i++)
				fieldp_hist[i] <= fieldp_hist[i-1];
			o_fieldwp <= fieldp_hist[`PAT_FIELD_LATENCY-1]; // latency+1 behind o_fieldp
		end
	end

	// operands, no reset needed
	always_ff @(posedge clk)
	begin
		o_alu_b <= src_dmem ? i_dmem_rdata : imm_next;
		o_field_value <= i_field_sel ? i_field_in_high : i_field_in_low;
		o_imm <= imm_next;
	end

	// one destination per instruction, commit relies on it
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({o_ctrl.dest_acc, o_ctrl.dest_field, o_ctrl.dest_dmem}));

endmodule

/* hdl/pat_commit.sv */
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_commit
(
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::ctrl_t     i_ctrl,
	input  pat_pkg::data_t     i_alu_b,
	input  pat_pkg::data_t     i_field_value,
	input  pat_pkg::data_t     i_imm,
	input  pat_pkg::data_t     i_acc_y,
	input  pat_pkg::data_t     i_field_y,
	input  pat_pkg::data_t     i_inputs,
	output pat_pkg::data_t     o_acc,
	output logic               o_field_sel,      // 1 = high half
	output logic               o_dmem_we,
	output pat_pkg::dmem_adr_t o_dmem_wadr,
	output pat_pkg::data_t     o_dmem_wdata,
	output pat_pkg::data_t     o_field_out,
	output logic               o_field_write_en_low,
	output logic               o_field_write_en_high,
	output pat_pkg::bufp_t     o_bufp,
	output pat_pkg::data_t     o_outputs
);

	logic           z, n;         // flags, set only by test
	logic           cond_ok;
	pat_pkg::data_t acc_result;
	pat_pkg::data_t field_result;

	// ==================================================
	// condition and result select
	// ==================================================
	always_comb
	begin
		case (i_ctrl.cond)
			`PAT_COND_Z: cond_ok = z;
			`PAT_COND_N: cond_ok = n;
			default:     cond_ok = 1'b1; // al, and code 3
		endcase
	end

	assign acc_result = i_ctrl.src_imm ? i_alu_b : i_ctrl.src_in ? i_inputs : i_acc_y;
	assign field_result = i_ctrl.src_imm ? i_alu_b : i_ctrl.src_in ? i_inputs : i_field_y;

	// memory write lands on the commit edge itself
	assign o_dmem_we = cond_ok && i_ctrl.dest_dmem;
	assign o_dmem_wadr = i_imm[`PAT_DMEM_ADR_WIDTH-1:0];
	assign o_dmem_wdata = i_ctrl.field_op ? i_field_value : o_acc;

	// ==================================================
	// architectural state
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_field_sel <= 1'b0;
			o_bufp <= '0;
			o_outputs <= '0;
			o_field_out <= '0;
			o_field_write_en_low <= 1'b0;
			o_field_write_en_high <= 1'b0;
		end
		else
		begin
			o_field_write_en_low <= 1'b0;  // enables pulse for one cycle
			o_field_write_en_high <= 1'b0;
			if (cond_ok)
			begin
				if (i_ctrl.dest_acc)
					o_acc <= i_ctrl.op_mov ? i_field_value : acc_result; // ldba
				if (i_ctrl.dest_field)
				begin
					o_field_out <= i_ctrl.op_mov ? o_acc : field_result; // ldab
					o_field_write_en_high <= o_field_sel;
					o_field_write_en_low <= !o_field_sel;
				end
				if (i_ctrl.op_test)
				begin
					z <= i_ctrl.field_op ? (i_field_value == '0) : (o_acc == '0);
					n <= i_ctrl.field_op ? i_field_value[$bits(pat_pkg::data_t)-1] :
						o_acc[$bits(pat_pkg::data_t)-1];
				end
				if (i_ctrl.op_out)
					o_outputs <= o_acc;
				if (i_ctrl.op_setb)
				begin
					o_bufp <= i_imm[2:0];
					o_field_sel <= i_imm[3];
				end
			end
		end
	end

	// only one half of the field buffer is written at a time
	assert property (@(posedge clk) disable iff (reset)
		!(o_field_write_en_low && o_field_write_en_high));

endmodule

/* hdl/pat_core.sv */
`timescale 1ns/1ps

module pat_core
(
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::instr_t  i_instruction,   // one per clock, no fetch
	input  pat_pkg::data_t   i_field_in_low,
	input  pat_pkg::data_t   i_field_in_high,
	input  pat_pkg::data_t   i_inputs,
	output pat_pkg::fieldp_t o_fieldp,
	output pat_pkg::fieldp_t o_fieldwp,
	output pat_pkg::bufp_t   o_bufp,
	output pat_pkg::data_t   o_field_out,
	output logic             o_field_write_en_low,
	output logic             o_field_write_en_high,
	output pat_pkg::data_t   o_outputs
);

	pat_pkg::ctrl_t     ctrl;
	pat_pkg::data_t     alu_b, field_value, imm;
	pat_pkg::data_t     acc, acc_y, field_y;
	logic               field_sel;
	pat_pkg::dmem_adr_t dmem_radr, dmem_wadr;
	pat_pkg::data_t     dmem_rdata, dmem_wdata;
	logic               dmem_we;

	// ==================================================
	// stage 1, decode and operand fetch
	// ==================================================
	pat_decode u_decode (.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_field_sel(field_sel), .i_field_in_low(i_field_in_low),
		.i_field_in_high(i_field_in_high), .i_dmem_rdata(dmem_rdata),
		.o_dmem_radr(dmem_radr), .o_ctrl(ctrl), .o_alu_b(alu_b),
		.o_field_value(field_value), .o_imm(imm), .o_fieldp(o_fieldp),
		.o_fieldwp(o_fieldwp));

	pat_data_mem u_dmem (.clk(clk), .i_radr(dmem_radr), .i_wadr(dmem_wadr),
		.i_we(dmem_we), .i_wdata(dmem_wdata), .o_rdata(dmem_rdata));

	// ==================================================
	// stage 2, alus and commit
	// ==================================================
	// separate alus so neither needs an a-input mux
	pat_alu acc_alu (.i_a(acc), .i_b(alu_b), .i_op(ctrl.alu_op), .o_y(acc_y));

	pat_alu field_alu (.i_a(field_value), .i_b(alu_b), .i_op(ctrl.alu_op), .o_y(field_y));

	pat_commit u_commit (.clk(clk), .reset(reset), .i_ctrl(ctrl), .i_alu_b(alu_b),
		.i_field_value(field_value), .i_imm(imm), .i_acc_y(acc_y),
		.i_field_y(field_y), .i_inputs(i_inputs), .o_acc(acc),
		.o_field_sel(field_sel), .o_dmem_we(dmem_we), .o_dmem_wadr(dmem_wadr),
		.o_dmem_wdata(dmem_wdata), .o_field_out(o_field_out),
		.o_field_write_en_low(o_field_write_en_low),
		.o_field_write_en_high(o_field_write_en_high),
		.o_bufp(o_bufp), .o_outputs(o_outputs));

endmodule

/* tb/pat_tb.sv */
`timescale 1ns/1ps
`include "pat_config.svh"

module pat_tb;

	// architectural state of the model, as seen at the outputs
	typedef struct packed
	{
		pat_pkg::data_t acc;
		pat_pkg::data_t out;
		pat_pkg::data_t fout;
		pat_pkg::bufp_t bufp;
		logic           z;
		logic           n;
		logic           fsel;
		logic           we_lo;
		logic           we_hi;
	} model_t;

	typedef struct packed
	{
		logic               we;
		pat_pkg::dmem_adr_t adr;
		pat_pkg::data_t     data;
	} mem_wr_t;

	logic               clk = 1'b0;
	logic               reset;
	pat_pkg::instr_t    i_instruction;
	pat_pkg::data_t     i_field_in_low, i_field_in_high, i_inputs;
	pat_pkg::fieldp_t   o_fieldp, o_fieldwp;
	pat_pkg::bufp_t     o_bufp;
	pat_pkg::data_t     o_field_out, o_outputs;
	logic               o_field_write_en_low, o_field_write_en_high;

	int                 seed = 89;
	int                 cycle_count = 0;
	int                 errors, test_errors, tests_run, tests_failed;
	string              test_name;
	pat_pkg::dmem_adr_t mem_adr;

	// stimulus per issue slot
	pat_pkg::instr_t    prog [$];
	pat_pkg::data_t     fin_lo [$], fin_hi [$], inp [$];

	model_t             m;
	mem_wr_t            pend;           // write of the previous instruction, not yet visible
	logic               fsel_seen;      // half select as decode sees it, one commit behind
	pat_pkg::data_t     m_mem [`PAT_DMEM_DEPTH];

	pat_core uut (.clk(clk), .reset(reset), .i_instruction(i_instruction),
		.i_field_in_low(i_field_in_low), .i_field_in_high(i_field_in_high),
		.i_inputs(i_inputs), .o_fieldp(o_fieldp), .o_fieldwp(o_fieldwp),
		.o_bufp(o_bufp), .o_field_out(o_field_out),
		.o_field_write_en_low(o_field_write_en_low),
		.o_field_write_en_high(o_field_write_en_high), .o_outputs(o_outputs));

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	// ==================================================
	// random instruction builders
	// ==================================================
	function automatic int rnd(input int range);
		return int'({$random(seed)} % range);
	endfunction

	function automatic pat_pkg::data_t rnd8();
		return pat_pkg::data_t'($random(seed));
	endfunction

	function automatic pat_pkg::instr_t enc_instr(input pat_pkg::cond_t cond, input logic fop,
		input logic [3:0] op8, input logic [7:0] imm8);
		pat_pkg::fieldp_t fp;
		fp = pat_pkg::fieldp_t'(rnd(32)); // any pointer, only o_fieldp cares
		return {fp, cond, fop, op8, imm8};
	endfunction

	// register ops without memory
	function automatic pat_pkg::instr_t alu_instr(input logic fop, input pat_pkg::cond_t cond);
		logic [7:0] r;
		r = rnd8();
		case (rnd(11))
			0: return enc_instr(cond, fop, 4'h0, r);              // or
			1: return enc_instr(cond, fop, 4'h1, r);              // and
			2: return enc_instr(cond, fop, 4'h4, r);              // add
			3: return enc_instr(cond, fop, 4'h5, r);              // sub
			4: return enc_instr(cond, fop, 4'h6, r);              // ldi
			5: return enc_instr(cond, fop, 4'hF, {4'h0, r[3:0]}); // shl
			6: return enc_instr(cond, fop, 4'hF, {4'h1, r[3:0]}); // shlo
			7: return enc_instr(cond, fop, 4'hF, {4'h2, r[3:0]}); // shr
			8: return enc_instr(cond, fop, 4'hF, {4'h3, r[3:0]}); // asr
			9: return enc_instr(cond, fop, 4'hF, {4'h5, r[3:0]}); // in
			default: return enc_instr(cond, fop, 4'hF, 8'hF0);    // not
		endcase
	endfunction

	// ldm, addm, subm, orm, andm on one address
	function automatic pat_pkg::instr_t mem_instr(input logic fop, input pat_pkg::cond_t cond,
		input pat_pkg::dmem_adr_t adr);
		logic [3:0] ops [5];
		ops = '{4'h7, 4'h2, 4'h3, 4'hD, 4'hE};
		return enc_instr(cond, fop, ops[rnd(5)], {4'(rnd(16)), adr});
	endfunction

	function automatic pat_pkg::instr_t any_instr(input logic fop, input pat_pkg::cond_t cond);
		logic [7:0] r;
		r = rnd8();
		case (rnd(8))
			0, 1: return alu_instr(fop, cond);
			2: return mem_instr(fop, cond, r[3:0]);
			3: return enc_instr(cond, fop, 4'hF, 8'hF1);            // mov
			4: return enc_instr(cond, fop, 4'hF, 8'hF2);            // test
			5: return enc_instr(cond, 1'b0, 4'hF, {4'h8, r[3:0]});  // out
			6: return enc_instr(cond, 1'b0, 4'hF, {4'h9, r[3:0]});  // setb
			default: return enc_instr(cond, fop, 4'hB, r);          // stm
		endcase
	endfunction

	// ==================================================
	// reference model
	// ==================================================
	function automatic pat_pkg::data_t shift_left(input pat_pkg::data_t v, input int s,
		input logic fill);
		pat_pkg::data_t t;
		t = v;
		for (int i = 0; i < s; i++)
			t = {t[6:0], fill}; // fill is 1 for shlo
		return t;
	endfunction

	function automatic pat_pkg::data_t shift_right(input pat_pkg::data_t v, input int s,
		input logic arith);
		pat_pkg::data_t t;
		t = v;
		for (int i = 0; i < s; i++)
			t = {arith ? t[7] : 1'b0, t[7:1]};
		return t;
	endfunction

	// commit of slot n, field inputs came one slot later, i_inputs two
	task automatic model_commit(input int n);
		pat_pkg::instr_t ins;
		logic [3:0]      op8;
		logic [7:0]      imm8;
		logic            fop, ok, is_i8, is_i3, wr;
		pat_pkg::data_t  b, memv, fv, a, r;
		ins = prog[n];
		op8 = ins[11:8];
		imm8 = ins[7:0];
		fop = ins[12];
		is_i8 = (op8 != 4'hF);
		is_i3 = !is_i8 && (imm8[7:4] != 4'hF);
		fv = fsel_seen ? fin_hi[n+1] : fin_lo[n+1];
		memv = m_mem[imm8[3:0]];          // read before the previous write lands
		if (pend.we)
			m_mem[pend.adr] = pend.data;
		pend = '0;
		fsel_seen = m.fsel;
		m.we_lo = 1'b0;
		m.we_hi = 1'b0;
		b = is_i8 ? imm8 : {4'h0, imm8[3:0]};
		a = fop ? fv : m.acc;
		case (ins[14:13])
			`PAT_COND_Z: ok = m.z;
			`PAT_COND_N: ok = m.n;
			default: ok = 1'b1;
		endcase
		if (ok)
		begin
			wr = 1'b1;
			r = a;
			if (is_i8)
				case (op8)
					4'h0: r = a | b;
					4'h1: r = a & b;
					4'h2: r = a + memv;
					4'h3: r = a - memv;
					4'h4: r = a + b;
					4'h5: r = a - b;
					4'h6: r = b;
					4'h7: r = memv;
					4'hD: r = a | memv;
					4'hE: r = a & memv;
					4'hB:
					begin
						pend = {1'b1, imm8[3:0], a}; // stm stores acc or field value
						wr = 1'b0;
					end
					default: wr = 1'b0;
				endcase
			else if (is_i3)
				case (imm8[7:4])
					4'h0: r = shift_left(a, int'(imm8[2:0]), 1'b0);
					4'h1: r = shift_left(a, int'(imm8[2:0]), 1'b1);
					4'h2: r = shift_right(a, int'(imm8[2:0]), 1'b0);
					4'h3: r = shift_right(a, int'(imm8[2:0]), 1'b1);
					4'h5: r = inp[n+2];
					4'h8:
					begin
						m.out = m.acc;
						wr = 1'b0;
					end
					4'h9:
					begin
						m.bufp = imm8[2:0];
						m.fsel = imm8[3];
						wr = 1'b0;
					end
					default: wr = 1'b0;
				endcase
			else
				case (imm8[3:0])
					4'h0: r = ~a;
					4'h1: r = fop ? m.acc : fv; // mov takes the other side
					4'h2:
					begin
						m.z = (a == 8'h00);
						m.n = a[7];
						wr = 1'b0;
					end
					default: wr = 1'b0;
				endcase
			if (wr && fop)
			begin
				m.fout = r;
				m.we_hi = m.fsel;
				m.we_lo = !m.fsel;
			end
			else if (wr)
				m.acc = r;
		end
	endtask

	// ==================================================
	// checking and stimulus
	// ==================================================
	function automatic pat_pkg::fieldp_t fp_of(input int idx);
		return (idx < 0) ? pat_pkg::fieldp_t'(0) : prog[idx][19:15];
	endfunction

	task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
		assert (act == exp)
		else
		begin
			$display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic compare_outputs(input int k);
		check_value("o_outputs", m.out, o_outputs);
		check_value("o_bufp", 8'(m.bufp), 8'(o_bufp));
		check_value("o_field_out", m.fout, o_field_out);
		check_value("o_field_write_en_low", 8'(m.we_lo), 8'(o_field_write_en_low));
		check_value("o_field_write_en_high", 8'(m.we_hi), 8'(o_field_write_en_high));
		check_value("o_fieldp", 8'(fp_of(k - 1)), 8'(o_fieldp));
		check_value("o_fieldwp", 8'(fp_of(k - 2 - `PAT_FIELD_LATENCY)), 8'(o_fieldwp));
	endtask

	// polls every 10 ns from 1 ns past an edge, so it wakes 1 ns after the next one
	task automatic next_edge();
		int start;
		int tries;
		start = cycle_count;
		tries = 0;
		while (cycle_count == start && tries < 20)
		begin
			#10;
			tries++;
		end
		if (cycle_count == start)
		begin
			$display("timeout, no rising clock edge within 200 ns");
			$display("Verification failed");
			$finish;
		end
	endtask

	task automatic issue(input pat_pkg::instr_t ins);
		int k;
		k = prog.size();
		prog.push_back(ins);
		fin_lo.push_back(rnd8());
		fin_hi.push_back(rnd8());
		inp.push_back(rnd8());
		i_instruction = ins;
		i_field_in_low = fin_lo[k];
		i_field_in_high = fin_hi[k];
		i_inputs = inp[k];
		next_edge();
		if (k >= 2)
			model_commit(k - 2); // slot k-2 committed on this edge
		compare_outputs(k);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic finish_test();
		issue(`PAT_INSTR_NOP); // drain the two slots still in flight
		issue(`PAT_INSTR_NOP);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: ok", test_name);
		else
		begin
			$display("test %s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial
	begin
		reset = 1'b1;
		i_instruction = `PAT_INSTR_NOP;
		i_field_in_low = '0;
		i_field_in_high = '0;
		i_inputs = '0;
		m = '0;
		pend = '0;
		fsel_seen = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		#1;
		next_edge();
		next_edge();
		reset = 1'b0;

		start_test("reset");
		repeat (8)
			issue(`PAT_INSTR_NOP);
		finish_test();

		start_test("acc_arith");
		repeat (40)
		begin
			issue(alu_instr(1'b0, `PAT_COND_AL));
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'hF, 8'h80)); // out
		end
		finish_test();

		start_test("memory");
		for (int a = 0; a < `PAT_DMEM_DEPTH; a++)
		begin
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'h6, rnd8()));
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'hB, {4'h0, 4'(a)}));
		end
		repeat (30)
		begin
			mem_adr = 4'(rnd(16));
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'h6, rnd8()));
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'hB, {4'h0, mem_adr}));
			issue(`PAT_INSTR_NOP);
			issue(mem_instr(1'b0, `PAT_COND_AL, mem_adr));
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'hF, 8'h80));
		end
		finish_test();

		start_test("field_ops");
		repeat (80)
			issue(any_instr(rnd(4) != 0, `PAT_COND_AL));
		finish_test();

		start_test("conditional");
		repeat (40)
		begin
			issue(enc_instr(`PAT_COND_AL, 1'b0, 4'h6, (rnd(3) == 0) ? 8'h00 : rnd8()));
			issue(enc_instr(`PAT_COND_AL, rnd(2) != 0, 4'hF, 8'hF2)); // test
			issue(alu_instr(rnd(2) != 0, pat_pkg::cond_t'(rnd(4))));
			issue(any_instr(rnd(2) != 0, pat_pkg::cond_t'(rnd(4))));
			issue(enc_instr(pat_pkg::cond_t'(rnd(4)), 1'b0, 4'hF, 8'h80));
		end
		finish_test();

		start_test("field_pointers");
		repeat (150)
			issue(any_instr(rnd(2) != 0, pat_pkg::cond_t'(rnd(4))));
		finish_test();

		$display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (tests_failed == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* compile.f */
+incdir+hdl
hdl/pat_pkg.sv
hdl/pat_alu.sv
hdl/pat_data_mem.sv
hdl/pat_decode.sv
hdl/pat_commit.sv
hdl/pat_core.sv
tb/pat_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pat_tb \
	-f compile.f -o pat_sim && ./obj_dir/pat_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Verification passed" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
